// File: Makefile
SIM := obj_dir/Vrange_enc_tb
SRCS := $(wildcard design/*.sv verification/*.sv)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): project.f $(SRCS)
	verilator --binary --timing --assert --top-module range_enc_tb -f project.f

# Fails unless the pass line shows up in the output
run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

// File: design/lzc_16.sv
// 16-bit leading zero counter
// Four nibble counters, then one more 4-bit counter over the nibble flags
`default_nettype none

module lzc_16 import range_enc_pkg::*; (
  input  range_t value,
  output d_t     count
);

  // Bit 2 flags an all-zero nibble, bits 1:0 count its leading zeros
  function automatic logic [2:0] lzc_4(input logic [3:0] x);
    logic [2:0] r;
    casez (x)
      4'b1???: r = 3'b000;
      4'b01??: r = 3'b001;
      4'b001?: r = 3'b010;
      4'b0001: r = 3'b011;
      default: r = 3'b100;
    endcase
    return r;
  endfunction

  logic [2:0] nib_lz [4];
  logic [3:0] nib_nz;
  logic [2:0] top_lz;
  logic [1:0] sel;

  // First level, one counter per nibble
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      nib_lz[i] = lzc_4(value[4*i +: 4]);
      nib_nz[i] = ~nib_lz[i][2];
    end
  end

  // Second level finds the first nonzero nibble from the top
  assign top_lz = lzc_4(nib_nz);
  assign sel    = 2'd3 - top_lz[1:0];
  // All zero gives the full width
  assign count  = top_lz[2] ? d_t'(RANGE_W) : {1'b0, top_lz[1:0], nib_lz[sel][1:0]};

endmodule

`default_nettype wire

// File: design/range_bool_update.sv
// Boolean range update at a fixed 50% probability
// Shift of at most two, picked from the top bits without a counter
`default_nettype none

module range_bool_update import range_enc_pkg::*; (
  input  range_t in_range,
  input  logic   bit_in,
  output range_t new_range,
  output d_t     d
);

  range_t v;
  range_t raw;

  // Half probability is 256 after the Q15 shift
  // so the product collapses to a shift of the top byte
  assign v = {1'b0, in_range[RANGE_W-1:8], 7'd0} + BOOL_OFFSET;

  // One keeps the lower part, zero the upper part
  assign raw = bit_in ? v : (in_range - v);

  // ------------------------------------------------------------
  // Renormalization
  // ------------------------------------------------------------
  // Worst case raw is 16380 for a range of 32768 and a zero bit
  // hence two is the largest shift
  always_comb begin
    if (raw[RANGE_W-1]) begin
      d = d_t'(0);
    end else if (raw[RANGE_W-2]) begin
      d = d_t'(1);
    end else begin
      d = d_t'(2);
    end
  end

  assign new_range = raw << d;

endmodule

`default_nettype wire

// File: design/range_cdf_update.sv
// Multi-symbol range update
// Scales the CDF bounds by the range and renormalizes with a leading-zero count
`default_nettype none

module range_cdf_update import range_enc_pkg::*; (
  input  range_t in_range,
  input  range_t uu,
  input  range_t vv,
  input  range_t lut_u,
  input  range_t lut_v,
  input  logic   comp_sel,
  output range_t new_range,
  output d_t     d
);

  logic [7:0]         r_hi;
  logic [RANGE_W+7:0] mul_u;
  logic [RANGE_W+7:0] mul_v;
  range_t             u;
  range_t             v;
  range_t             raw;

  // ------------------------------------------------------------
  // Scaled bounds
  // ------------------------------------------------------------
  // Only the top byte of the range takes part
  assign r_hi = in_range[RANGE_W-1:8];

  // uu and vv stay below 2^10, so the products fit in 18 bits
  assign mul_u = {{RANGE_W{1'b0}}, r_hi} * {8'd0, uu};
  assign mul_v = {{RANGE_W{1'b0}}, r_hi} * {8'd0, vv};

  // Upper bound
  assign u = mul_u[RANGE_W:1] + lut_u;
  // Lower bound
  assign v = mul_v[RANGE_W:1] + lut_v;

  // ------------------------------------------------------------
  // Raw range
  // ------------------------------------------------------------
  // First symbol keeps the top of the interval
  assign raw = comp_sel ? (u - v) : (in_range - v);

  // ------------------------------------------------------------
  // Renormalization
  // ------------------------------------------------------------
  // Shift amount for the bit packer
  lzc_16 i_lzc (
    .value (raw),
    .count (d)
  );

  // Top bit set again after the shift
  assign new_range = raw << d;

endmodule

`default_nettype wire

// File: design/range_enc_pkg.sv
// Range encoder shared definitions
// Widths, reset range and the two-way decoded input word
`default_nettype none

package range_enc_pkg;

  // ------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------
  // Range register
  localparam int RANGE_W = 16;
  // Renormalization shift amount
  localparam int D_W     = 5;
  // Symbol index and alphabet size
  localparam int SYM_W   = 4;

  typedef logic [RANGE_W-1:0] range_t;
  typedef logic [D_W-1:0]     d_t;

  // Range after reset
  localparam range_t RANGE_INIT  = 16'd32768;
  // Minimum probability term of the boolean update
  localparam range_t BOOL_OFFSET = 16'd4;

  // ------------------------------------------------------------
  // Input word of 40 bits
  // ------------------------------------------------------------
  // Kind flag in_is_bool selects the view
  typedef union packed {
    // Inverted Q15 frequencies, symbol, alphabet size minus one
    struct packed {
      logic [RANGE_W-1:0] fl;
      logic [RANGE_W-1:0] fh;
      logic [SYM_W-1:0]   s;
      logic [SYM_W-1:0]   n;
    } cdf;
    // Up to three equiprobable bins, bit 0 is coded first
    struct packed {
      logic [2*RANGE_W+2*SYM_W-6:0] pad;
      logic [1:0]                   count;
      logic [2:0]                   bits;
    } bool;
  } sym_word_u;

endpackage

`default_nettype wire

// File: design/range_enc_top.sv
// Range encoder top level
// Two-stage range update with valid/ready at both ends
`default_nettype none

module range_enc_top import range_enc_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  // Input word
  input  sym_word_u  in_word,
  input  logic       in_is_bool,
  input  logic       in_valid,
  output logic       in_ready,
  // Updated range and shifts
  output range_t     out_range,
  output d_t         out_d_1,
  output d_t         out_d_2,
  output d_t         out_d_3,
  output logic       out_is_bool,
  output logic [1:0] out_count,
  output logic       out_valid,
  input  logic       out_ready
);

  // ------------------------------------------------------------
  // Stage 1 to stage 2
  // ------------------------------------------------------------
  logic       s1_valid;
  logic       s1_ready;
  range_t     uu;
  range_t     vv;
  range_t     lut_u;
  range_t     lut_v;
  logic       comp_sel;
  logic       is_bool;
  logic [2:0] bool_bits;
  logic [1:0] bool_count;

  // Decode and symbol-only precompute
  range_stage_1 i_stage_1 (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_word    (in_word),
    .in_is_bool (in_is_bool),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .s1_valid   (s1_valid),
    .s1_ready   (s1_ready),
    .uu         (uu),
    .vv         (vv),
    .lut_u      (lut_u),
    .lut_v      (lut_v),
    .comp_sel   (comp_sel),
    .is_bool    (is_bool),
    .bool_bits  (bool_bits),
    .bool_count (bool_count)
  );

  // Range state and renormalization
  range_stage_2 i_stage_2 (
    .clk         (clk),
    .rst_n       (rst_n),
    .s1_valid    (s1_valid),
    .s1_ready    (s1_ready),
    .uu          (uu),
    .vv          (vv),
    .lut_u       (lut_u),
    .lut_v       (lut_v),
    .comp_sel    (comp_sel),
    .is_bool     (is_bool),
    .bool_bits   (bool_bits),
    .bool_count  (bool_count),
    .out_range   (out_range),
    .out_d_1     (out_d_1),
    .out_d_2     (out_d_2),
    .out_d_3     (out_d_3),
    .out_is_bool (out_is_bool),
    .out_count   (out_count),
    .out_valid   (out_valid),
    .out_ready   (out_ready)
  );

endmodule

`default_nettype wire

// File: design/range_stage_1.sv
// Encoder stage 1
// Decodes the input word and registers the symbol-only operands
`default_nettype none

module range_stage_1 import range_enc_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  sym_word_u  in_word,
  input  logic       in_is_bool,
  input  logic       in_valid,
  output logic       in_ready,
  output logic       s1_valid,
  input  logic       s1_ready,
  output range_t     uu,
  output range_t     vv,
  output range_t     lut_u,
  output range_t     lut_v,
  output logic       comp_sel,
  output logic       is_bool,
  output logic [2:0] bool_bits,
  output logic [1:0] bool_count
);

  logic           load;
  logic [SYM_W:0] span;

  // Empty, or draining into stage 2 this cycle
  assign in_ready = ~s1_valid | s1_ready;
  assign load     = in_valid & in_ready;

  // N minus s, never negative for a legal symbol
  assign span = {1'b0, in_word.cdf.n} - {1'b0, in_word.cdf.s};

  // ------------------------------------------------------------
  // Valid flag
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else if (in_ready) begin
      s1_valid <= in_valid;
    end
  end

  // ------------------------------------------------------------
  // Operand register
  // ------------------------------------------------------------
  // Unused view is zeroed to keep the other datapath quiet
  always_ff @(posedge clk) begin
    if (load) begin
      is_bool <= in_is_bool;
      if (in_is_bool) begin
        uu         <= '0;
        vv         <= '0;
        lut_u      <= '0;
        lut_v      <= '0;
        comp_sel   <= 1'b0;
        bool_bits  <= in_word.bool.bits;
        bool_count <= in_word.bool.count;
      end else begin
        // Q15 frequencies down to 10 bits
        uu         <= in_word.cdf.fl >> 6;
        vv         <= in_word.cdf.fh >> 6;
        // Minimum probability terms, 4 per remaining symbol
        lut_u      <= range_t'({span + 5'd1, 2'b00});
        lut_v      <= range_t'({span, 2'b00});
        // Symbol zero takes range minus v
        comp_sel   <= (in_word.cdf.s != '0);
        bool_bits  <= 3'd0;
        bool_count <= 2'd0;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/range_stage_2.sv
// Encoder stage 2
// Range state, CDF or chained boolean update, and the output register
`default_nettype none

module range_stage_2 import range_enc_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       s1_valid,
  output logic       s1_ready,
  input  range_t     uu,
  input  range_t     vv,
  input  range_t     lut_u,
  input  range_t     lut_v,
  input  logic       comp_sel,
  input  logic       is_bool,
  input  logic [2:0] bool_bits,
  input  logic [1:0] bool_count,
  output range_t     out_range,
  output d_t         out_d_1,
  output d_t         out_d_2,
  output d_t         out_d_3,
  output logic       out_is_bool,
  output logic [1:0] out_count,
  output logic       out_valid,
  input  logic       out_ready
);

  logic       accept;
  logic [2:0] en;
  logic [2:0] chain_bit;
  range_t     chain_in  [3];
  range_t     chain_out [3];
  d_t         chain_d   [3];
  range_t     cdf_range;
  d_t         cdf_d;
  range_t     next_range;
  range_t     range_q;

  // Output register free or draining
  assign s1_ready = ~out_valid | out_ready;
  assign accept   = s1_valid & s1_ready;

  // Bins in use
  assign en[0] = is_bool & (bool_count != 2'd0);
  assign en[1] = is_bool & bool_count[1];
  assign en[2] = is_bool & (bool_count == 2'd3);

  // ------------------------------------------------------------
  // CDF path
  // ------------------------------------------------------------
  range_cdf_update i_cdf (
    .in_range  (range_q),
    .uu        (uu),
    .vv        (vv),
    .lut_u     (lut_u),
    .lut_v     (lut_v),
    .comp_sel  (comp_sel),
    .new_range (cdf_range),
    .d         (cdf_d)
  );

  // ------------------------------------------------------------
  // Boolean chain
  // ------------------------------------------------------------
  // Each bin starts from the previous bin's range
  // Operand isolation for bins not in the bundle
  for (genvar i = 0; i < 3; i++) begin : g_bool
    if (i == 0) begin : g_head
      assign chain_in[i] = en[i] ? range_q : '0;
    end else begin : g_link
      assign chain_in[i] = en[i] ? chain_out[i-1] : '0;
    end
    assign chain_bit[i] = en[i] & bool_bits[i];

    range_bool_update i_bool (
      .in_range  (chain_in[i]),
      .bit_in    (chain_bit[i]),
      .new_range (chain_out[i]),
      .d         (chain_d[i])
    );
  end

  // Range after the last counted bin
  always_comb begin
    if (!is_bool) begin
      next_range = cdf_range;
    end else begin
      case (bool_count)
        2'd3:    next_range = chain_out[2];
        2'd2:    next_range = chain_out[1];
        2'd1:    next_range = chain_out[0];
        default: next_range = range_q;
      endcase
    end
  end

  // ------------------------------------------------------------
  // State and output registers
  // ------------------------------------------------------------
  // Range state doubles as the output range
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      range_q   <= RANGE_INIT;
    end else begin
      if (s1_ready) begin
        out_valid <= s1_valid;
      end
      if (accept) begin
        range_q <= next_range;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      out_d_1     <= is_bool ? (en[0] ? chain_d[0] : '0) : cdf_d;
      out_d_2     <= en[1] ? chain_d[1] : '0;
      out_d_3     <= en[2] ? chain_d[2] : '0;
      out_is_bool <= is_bool;
      out_count   <= bool_count;
    end
  end

  assign out_range = range_q;

endmodule

`default_nettype wire

// File: project.f
design/range_enc_pkg.sv
design/lzc_16.sv
design/range_cdf_update.sv
design/range_bool_update.sv
design/range_stage_1.sv
design/range_stage_2.sv
design/range_enc_top.sv
verification/range_enc_assert.sv
verification/range_enc_tb.sv

// File: verification/range_enc_assert.sv
// Range encoder output protocol checks
// Idle in reset, hold under back-pressure, normalized output range
`default_nettype none

module range_enc_assert import range_enc_pkg::*; (
  input logic       clk,
  input logic       rst_n,
  input range_t     out_range,
  input d_t         out_d_1,
  input d_t         out_d_2,
  input d_t         out_d_3,
  input logic       out_is_bool,
  input logic [1:0] out_count,
  input logic       out_valid,
  input logic       out_ready
);

  // No output while in reset
  a_reset_idle: assert property (@(posedge clk) !rst_n |-> !out_valid)
    else $error("out_valid high during reset");

  // Stalled output keeps valid and every field
  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_range)
      && $stable(out_d_1) && $stable(out_d_2) && $stable(out_d_3)
      && $stable(out_is_bool) && $stable(out_count))
    else $error("output changed while stalled");

  // Top bit always set after renormalization
  a_norm: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> out_range[RANGE_W-1])
    else $error("out_range not normalized");

endmodule

`default_nettype wire

// File: verification/range_enc_tb.sv
// Range encoder testbench
// Random CDF and boolean words with stalls, checked against a running range model
`default_nettype none

module range_enc_tb import range_enc_pkg::*; ();

  localparam int N_ITEMS  = 400;
  localparam int MAX_WAIT = 64;

  logic       clk;
  logic       rst_n;
  sym_word_u  in_word;
  logic       in_is_bool;
  logic       in_valid;
  logic       in_ready;
  range_t     out_range;
  d_t         out_d_1;
  d_t         out_d_2;
  d_t         out_d_3;
  logic       out_is_bool;
  logic [1:0] out_count;
  logic       out_valid;
  logic       out_ready;

  logic [31:0] lfsr;
  range_t      model_range;
  // Expected outputs in input order
  range_t      q_range [$];
  d_t          q_d1 [$];
  d_t          q_d2 [$];
  d_t          q_d3 [$];
  logic        q_is_bool [$];
  logic [1:0]  q_count [$];
  int          sent;
  int          received;
  int          in_wait;
  int          out_wait;
  int          cycles;
  logic        accepted;

  range_enc_top i_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_word     (in_word),
    .in_is_bool  (in_is_bool),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .out_range   (out_range),
    .out_d_1     (out_d_1),
    .out_d_2     (out_d_2),
    .out_d_3     (out_d_3),
    .out_is_bool (out_is_bool),
    .out_count   (out_count),
    .out_valid   (out_valid),
    .out_ready   (out_ready)
  );

  bind range_enc_top range_enc_assert i_assert (
    .clk         (clk),
    .rst_n       (rst_n),
    .out_range   (out_range),
    .out_d_1     (out_d_1),
    .out_d_2     (out_d_2),
    .out_d_3     (out_d_3),
    .out_is_bool (out_is_bool),
    .out_count   (out_count),
    .out_valid   (out_valid),
    .out_ready   (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ------------------------------------------------------------
  // Random bits and failure exit
  // ------------------------------------------------------------
  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return r;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  // ------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------
  task automatic check_range(input string name, input range_t exp, input range_t act);
    if (exp !== act) begin
      abort_run($sformatf("Error: %s expected 0x%h, got 0x%h", name, exp, act));
    end
  endtask

  task automatic check_d(input string name, input d_t exp, input d_t act);
    if (exp !== act) begin
      abort_run($sformatf("Error: %s expected 0x%h, got 0x%h", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (exp !== act) begin
      abort_run($sformatf("Error: %s expected 0x%h, got 0x%h", name, exp, act));
    end
  endtask

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------
  // Leading zeros of the raw range, 16 for zero
  function automatic d_t lead_zeros(input range_t x);
    d_t n;
    n = d_t'(RANGE_W);
    for (int i = 0; i < RANGE_W; i++) begin
      if (x[i]) begin
        n = d_t'(RANGE_W - 1 - i);
      end
    end
    return n;
  endfunction

  // Advance the model range for one accepted word and queue its outputs
  task automatic predict(input sym_word_u w, input logic is_b);
    int     r;
    int     u;
    int     v;
    range_t raw;
    d_t     d [3];
    for (int i = 0; i < 3; i++) begin
      d[i] = '0;
    end
    if (!is_b) begin
      // Top byte of the range times the 10-bit bounds, plus 4 per symbol left
      r     = int'(model_range >> 8);
      u     = ((r * int'(w.cdf.fl >> 6)) >> 1) + 4 * (int'(w.cdf.n) - int'(w.cdf.s) + 1);
      v     = ((r * int'(w.cdf.fh >> 6)) >> 1) + 4 * (int'(w.cdf.n) - int'(w.cdf.s));
      raw   = (w.cdf.s != 0) ? range_t'(u - v) : range_t'(int'(model_range) - v);
      d[0]  = lead_zeros(raw);
      model_range = raw << d[0];
    end else begin
      // Bins chain through the range one after the other
      for (int i = 0; i < 3; i++) begin
        if (i < int'(w.bool.count)) begin
          v    = ((int'(model_range) >> 8) << 7) + 4;
          raw  = w.bool.bits[i] ? range_t'(v) : range_t'(int'(model_range) - v);
          d[i] = lead_zeros(raw);
          model_range = raw << d[i];
        end
      end
    end
    q_range.push_back(model_range);
    q_d1.push_back(d[0]);
    q_d2.push_back(d[1]);
    q_d3.push_back(d[2]);
    q_is_bool.push_back(is_b);
    q_count.push_back(is_b ? w.bool.count : 2'd0);
  endtask

  // ------------------------------------------------------------
  // Stimulus and output check
  // ------------------------------------------------------------
  // Legal CDF symbol or a bundle of one to three bins
  task automatic next_word();
    sym_word_u  w;
    logic [3:0] n;
    logic [3:0] s;
    int         fl;
    w = '0;
    in_is_bool = rand_bits(1) != 0;
    if (in_is_bool) begin
      w.bool.count = 2'(1 + rand_bits(8) % 3);
      w.bool.bits  = 3'(rand_bits(3));
    end else begin
      n  = 4'(rand_bits(4));
      s  = 4'(rand_bits(4) % (n + 1));
      fl = (s == 0) ? 32768 : int'(rand_bits(15));
      if (fl < 64) begin
        fl += 64;
      end
      // FH at least 64 below FL
      w.cdf.fl = 16'(fl);
      w.cdf.fh = 16'(int'(rand_bits(16)) % (fl - 63));
      w.cdf.s  = s;
      w.cdf.n  = n;
    end
    in_word = w;
  endtask

  task automatic check_outputs();
    if (!out_range[RANGE_W-1]) begin
      abort_run($sformatf("Error: out_range not normalized, got 0x%h", out_range));
    end
    check_range("out_range", q_range.pop_front(), out_range);
    check_d("out_d_1", q_d1.pop_front(), out_d_1);
    check_d("out_d_2", q_d2.pop_front(), out_d_2);
    check_d("out_d_3", q_d3.pop_front(), out_d_3);
    check_flag("out_is_bool", {1'b0, q_is_bool.pop_front()}, {1'b0, out_is_bool});
    check_flag("out_count", q_count.pop_front(), out_count);
  endtask

  initial begin
    lfsr        = 32'd68623;
    model_range = RANGE_INIT;
    sent        = 0;
    received    = 0;
    in_wait     = 0;
    out_wait    = 0;
    cycles      = 0;
    accepted    = 1'b0;
    in_word     = '0;
    in_is_bool  = 1'b0;
    in_valid    = 1'b0;
    out_ready   = 1'b0;
    rst_n       = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst_n     = 1'b1;
    out_ready = 1'b1;
    @(negedge clk);
    if (out_valid || !in_ready) begin
      abort_run("Pipeline not idle and ready after reset");
    end

    while (received < N_ITEMS) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > N_ITEMS * 16) begin
        abort_run("Timeout: run did not complete all words");
      end
      // Drop valid after a transfer, maybe present the next word at once
      if (accepted) begin
        in_valid = 1'b0;
      end
      if (!in_valid && sent < N_ITEMS && (sent < 32 || rand_bits(2) != 0)) begin
        next_word();
        in_valid = 1'b1;
      end
      // First words run without stalls
      out_ready = (received < 32) || (rand_bits(2) != 0);

      // Mid-cycle sample, transfers happen on the next rising edge
      @(negedge clk);
      if (out_valid && out_ready) begin
        if (q_range.size() == 0) begin
          abort_run("Output transfer with no word pending");
        end
        check_outputs();
        received++;
        out_wait = 0;
      end else if (q_range.size() != 0) begin
        out_wait++;
        if (out_wait > MAX_WAIT) begin
          abort_run("Timeout: out_valid never completed a transfer for a pending word");
        end
      end
      accepted = in_valid && in_ready;
      if (accepted) begin
        predict(in_word, in_is_bool);
        sent++;
        in_wait = 0;
      end else if (in_valid) begin
        in_wait++;
        if (in_wait > MAX_WAIT) begin
          abort_run("Timeout: in_ready stayed low with a word waiting");
        end
      end
    end

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire
